//--- verilog.f
+incdir+.
csi2_video_pkg.sv
csi2_csr_pkg.sv
csi2_stat_acc.sv
csi2_csr.sv
cam_pwup_seq.sv
csi2_stat_top.sv
tb_csi2_stat.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the CSI-2 statistics testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_csi2_stat -f verilog.f -o sim_tb_csi2_stat > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/sim_tb_csi2_stat > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "Simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q "TESTBENCH PASSED" sim.log; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed, see sim.log"
exit 1

//--- tb_csi2_stat.sv
`include "csi2_cfg.svh"

module tb_csi2_stat;

timeunit 1ns;
timeprecision 100ps;

import csi2_video_pkg::*;
import csi2_csr_pkg::*;

localparam int WIN = `CSI2_FPS_WINDOW;
localparam int DELAY = `CSI2_PWUP_DELAY;
// Test 6 spans under three windows and the other tests are short
localparam int MAX_CYC = 10 * WIN;

logic        clk;
logic        reset;
video_beat_t video;
err_flags_t  err;
csr_req_t    host_req;
csr_rsp_t    host_rsp;
logic        phy_en;
logic [6 : 0] sccb_addr;
lane_delay_t lane_delay;
logic        delay_act;
logic        cam_pwup;
logic        init_done;

int cyc = 0;
int rel_cyc = 0;
int errors = 0;
int errors_at_start = 0;
int pass_cnt = 0;
int fail_cnt = 0;

// Reference model state
int        hdr_m = 0;
int        corr_m = 0;
int        crc_m = 0;
int        max_px_m = 0;
int        min_px_m = 16'hffff;
int        max_ln_m = 0;
int        min_ln_m = 16'hffff;
int        lines_m = 0;
bit        frame_open = 0;
csr_data_t lane_m = '0;
int        sof_k[$];

csi2_stat_top dut (
  .px_clk_i          ( clk        ),
  .reset_i           ( reset      ),
  .video_i           ( video      ),
  .err_i             ( err        ),
  .host_req_i        ( host_req   ),
  .host_rsp_o        ( host_rsp   ),
  .phy_en_o          ( phy_en     ),
  .sccb_slave_addr_o ( sccb_addr  ),
  .lane_delay_o      ( lane_delay ),
  .delay_act_o       ( delay_act  ),
  .cam_pwup_o        ( cam_pwup   ),
  .init_done_o       ( init_done  )
);

initial begin
  clk = 1'b0;
  forever #4 clk = ~clk;
end

always @(posedge clk) begin
  cyc = cyc + 1;
  if (cyc >= MAX_CYC) begin
    $display("Run timed out after %0d cycles", cyc);
    $display("TESTBENCH FAILED");
    $finish;
  end
end

task automatic check(input string what, input logic [31 : 0] got, input logic [31 : 0] exp);
  assert (got === exp)
  else begin
    $display("ERR %0d ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
    errors++;
  end
endtask

task automatic finish_test(input string name);
  if (errors == errors_at_start) begin
    pass_cnt++;
    $display("test %s: ok", name);
  end else begin
    fail_cnt++;
    $display("test %s: %0d errors", name, errors - errors_at_start);
  end
  errors_at_start = errors;
endtask

task automatic idle(input int n);
  repeat (n) begin
    @(posedge clk);
    #1;
  end
endtask

task automatic reg_write(input csr_addr_t addr, input csr_data_t data);
  @(posedge clk);
  #1;
  host_req = '{wr: 1'b1, rd: 1'b0, addr: addr, wdata: data};
  @(posedge clk);
  #1;
  host_req = '0;
endtask

task automatic reg_read(input csr_addr_t addr, output csr_data_t data, output bit got);
  got = 0;
  data = '0;
  @(posedge clk);
  #1;
  host_req = '{wr: 1'b0, rd: 1'b1, addr: addr, wdata: '0};
  for (int i = 0; i < 4 && !got; i++) begin
    @(posedge clk);
    #1;
    host_req = '0;
    if (host_rsp.rvalid) begin
      got = 1;
      data = host_rsp.rdata;
    end
  end
endtask

task automatic read_check(input string what, input csr_addr_t addr, input csr_data_t exp);
  csr_data_t data;
  bit        got;
  reg_read(addr, data, got);
  assert (got)
  else begin
    $display("Read of %s got no response within 4 cycles", what);
    errors++;
  end
  if (got)
    check(what, data, exp);
endtask

// Counts cycles to the power pin and init while host traffic is dropped
task automatic power_up_with_host_blocked();
  int        n;
  csr_data_t data;
  bit        got;
  n = 0;
  fork
    begin
      while (!cam_pwup && n <= DELAY + 4) begin
        @(posedge clk);
        #1;
        n++;
      end
      check("cycles to cam_pwup_o", n, DELAY);
      n = 0;
      while (!init_done && n <= 8) begin
        @(posedge clk);
        #1;
        n++;
      end
      check("cycles from cam_pwup_o to init_done_o", n, 3);
    end
    begin
      reg_write(LANE_DELAY, ~lane_m & 32'h1f1f);
      reg_read(LANE_DELAY, data, got);
      check("rvalid for a read before init", got, 0);
    end
  join
  check("lane_delay_o after blocked write", lane_delay, {lane_m[12 : 8], lane_m[4 : 0]});
  read_check("CTRL", CTRL, 1);
  read_check("SCCB_ADDR", SCCB_ADDR, `CSI2_SCCB_ADDR_DEFAULT);
  check("phy_en_o", phy_en, 1);
  check("sccb_slave_addr_o", sccb_addr, `CSI2_SCCB_ADDR_DEFAULT);
endtask

task automatic drive_beat(input bit sof, input bit eol);
  @(posedge clk);
  #1;
  video = '{valid: 1'b1, sof: sof, eol: eol, data: 16'($urandom)};
  if (sof) begin
    // Sampled on the next edge and counted from the reset edge
    sof_k.push_back(cyc + 1 - rel_cyc);
    if (frame_open) begin
      if (lines_m > max_ln_m)
        max_ln_m = lines_m;
      if (lines_m < min_ln_m)
        min_ln_m = lines_m;
    end
    frame_open = 1;
    lines_m = 0;
  end
endtask

task automatic end_video();
  @(posedge clk);
  #1;
  video = '0;
endtask

task automatic send_frame(input int lines, input int max_len);
  int len;
  for (int l = 0; l < lines; l++) begin
    len = 1 + int'($urandom % max_len);
    for (int p = 0; p < len; p++)
      drive_beat(l == 0 && p == 0, p == len - 1);
    lines_m++;
    if (len > max_px_m)
      max_px_m = len;
    if (len < min_px_m)
      min_px_m = len;
  end
  end_video();
endtask

task automatic pulse_errors(input int n);
  logic [2 : 0] bits;
  repeat (n) begin
    @(posedge clk);
    #1;
    bits = 3'($urandom);
    err = bits;
    hdr_m += int'(err.header_err);
    corr_m += int'(err.corr_header_err);
    crc_m += int'(err.crc_err);
  end
  @(posedge clk);
  #1;
  err = '0;
endtask

// FPS seen by a read sampled at edge k after reset
function automatic int fps_expected(input int k);
  int last_end;
  int n;
  last_end = ((k - 1) / WIN) * WIN;
  n = 0;
  foreach (sof_k[i])
    if (sof_k[i] > last_end - WIN && sof_k[i] <= last_end)
      n++;
  return n;
endfunction

initial begin
  int unsigned seed;
  bit          phy;
  int          t0;
  int          k;
  reset = 1'b1;
  video = '0;
  err = '0;
  host_req = '0;
  seed = $urandom(64082);
  repeat (4) @(posedge clk);
  #1;
  reset = 1'b0;
  rel_cyc = cyc;

  check("outputs after reset", {phy_en, delay_act, cam_pwup, init_done, host_rsp.rvalid}, 0);
  power_up_with_host_blocked();
  finish_test("power-up");

  lane_m = csr_data_t'(($urandom % 32) << 8) | csr_data_t'($urandom % 32);
  reg_write(LANE_DELAY, lane_m);
  check("delay_act_o pulse", delay_act, 1);
  check("lane_delay_o", lane_delay, {lane_m[12 : 8], lane_m[4 : 0]});
  idle(1);
  check("delay_act_o after pulse", delay_act, 0);
  read_check("LANE_DELAY", LANE_DELAY, lane_m);
  finish_test("bus ownership");

  pulse_errors(60);
  read_check("HDR_ERR", HDR_ERR, hdr_m);
  read_check("CORR_ERR", CORR_ERR, corr_m);
  read_check("CRC_ERR", CRC_ERR, crc_m);
  finish_test("error counters");

  repeat (3) send_frame(2 + int'($urandom % 4), 12);
  drive_beat(1, 0);
  end_video();
  idle(2);
  read_check("MAX_LN", MAX_LN, max_ln_m);
  read_check("MIN_LN", MIN_LN, min_ln_m);
  read_check("MAX_PX", MAX_PX, max_px_m);
  read_check("MIN_PX", MIN_PX, min_px_m);
  finish_test("line and pixel extremes");

  phy = 1'($urandom);
  reg_write(CTRL, csr_data_t'(phy) | 32'h2);
  frame_open = 0;
  lines_m = 0;
  max_px_m = 0;
  min_px_m = 16'hffff;
  max_ln_m = 0;
  min_ln_m = 16'hffff;
  idle(2);
  read_check("HDR_ERR", HDR_ERR, 0);
  read_check("CORR_ERR", CORR_ERR, 0);
  read_check("CRC_ERR", CRC_ERR, 0);
  read_check("MAX_LN", MAX_LN, 0);
  read_check("MIN_LN", MIN_LN, 16'hffff);
  read_check("MAX_PX", MAX_PX, 0);
  read_check("MIN_PX", MIN_PX, 16'hffff);
  read_check("CTRL", CTRL, phy);
  check("phy_en_o after clear", phy_en, phy);
  finish_test("clear");

  t0 = cyc;
  while (cyc - t0 < 2 * WIN + WIN / 4) begin
    send_frame(3, 8);
    idle(40);
  end
  k = cyc + 2 - rel_cyc;
  read_check("FPS", FPS, fps_expected(k));
  reg_write(CTRL, 32'h5);
  idle(1);
  check("cam_pwup_o after cam_rst", cam_pwup, 0);
  check("init_done_o after cam_rst", init_done, 0);
  power_up_with_host_blocked();
  finish_test("frame rate and camera reset");

  $display("Tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
  if (fail_cnt == 0) begin
    $display("TESTBENCH PASSED");
  end else begin
    $display("TESTBENCH FAILED");
  end
  $finish;
end

endmodule

//--- csi2_stat_top.sv
module csi2_stat_top (
  input                               px_clk_i,
  input                               reset_i,
  input  csi2_video_pkg::video_beat_t video_i,
  input  csi2_video_pkg::err_flags_t  err_i,
  input  csi2_csr_pkg::csr_req_t      host_req_i,
  output csi2_csr_pkg::csr_rsp_t      host_rsp_o,
  output logic                        phy_en_o,
  output logic [6 : 0]                sccb_slave_addr_o,
  output csi2_csr_pkg::lane_delay_t   lane_delay_o,
  output logic                        delay_act_o,
  output logic                        cam_pwup_o,
  output logic                        init_done_o
);

import csi2_video_pkg::*;
import csi2_csr_pkg::*;

csr_req_t csr_req;
csr_rsp_t csr_rsp;
stat_t    stat;
logic     clear_stat;
logic     cam_rst_stb;

// Power-up timing and register bus master select
cam_pwup_seq cam_pwup_seq (
  .px_clk_i      ( px_clk_i    ),
  .reset_i       ( reset_i     ),
  .cam_rst_stb_i ( cam_rst_stb ),
  .host_req_i    ( host_req_i  ),
  .host_rsp_o    ( host_rsp_o  ),
  .csr_rsp_i     ( csr_rsp     ),
  .csr_req_o     ( csr_req     ),
  .cam_pwup_o    ( cam_pwup_o  ),
  .init_done_o   ( init_done_o )
);

csi2_csr csi2_csr (
  .px_clk_i          ( px_clk_i          ),
  .reset_i           ( reset_i           ),
  .req_i             ( csr_req           ),
  .rsp_o             ( csr_rsp           ),
  .stat_i            ( stat              ),
  .phy_en_o          ( phy_en_o          ),
  .clear_stat_o      ( clear_stat        ),
  .cam_rst_stb_o     ( cam_rst_stb       ),
  .sccb_slave_addr_o ( sccb_slave_addr_o ),
  .lane_delay_o      ( lane_delay_o      ),
  .delay_act_o       ( delay_act_o       )
);

csi2_stat_acc csi2_stat_acc (
  .px_clk_i     ( px_clk_i   ),
  .reset_i      ( reset_i    ),
  .clear_stat_i ( clear_stat ),
  .video_i      ( video_i    ),
  .err_i        ( err_i      ),
  .stat_o       ( stat       )
);

endmodule

//--- cam_pwup_seq.sv
`include "csi2_cfg.svh"

module cam_pwup_seq (
  input                          px_clk_i,
  input                          reset_i,
  input                          cam_rst_stb_i,
  input  csi2_csr_pkg::csr_req_t host_req_i,
  output csi2_csr_pkg::csr_rsp_t host_rsp_o,
  input  csi2_csr_pkg::csr_rsp_t csr_rsp_i,
  output csi2_csr_pkg::csr_req_t csr_req_o,
  output logic                   cam_pwup_o,
  output logic                   init_done_o
);

import csi2_csr_pkg::*;

localparam int DLY_W = $clog2(`CSI2_PWUP_DELAY + 1);

typedef enum logic [1 : 0] {
  WAIT_PWR,
  WR_CTRL,
  WR_ADDR,
  DONE
} state_t;

state_t               state;
logic [DLY_W - 1 : 0] dly_cnt;
csr_req_t             seq_req;

always_ff @( posedge px_clk_i ) begin
  if( reset_i || cam_rst_stb_i ) begin
    state      <= WAIT_PWR;
    dly_cnt    <= '0;
    cam_pwup_o <= 1'b0;
  end else begin
    case( state )
      WAIT_PWR: begin
        // Power pin rises one cycle ahead of the first write
        if( dly_cnt == DLY_W'(`CSI2_PWUP_DELAY - 1) )
          cam_pwup_o <= 1'b1;
        if( dly_cnt == DLY_W'(`CSI2_PWUP_DELAY) )
          state <= WR_CTRL;
        else
          dly_cnt <= dly_cnt + 1'b1;
      end
      WR_CTRL: state <= WR_ADDR;
      WR_ADDR: state <= DONE;
      default: state <= DONE;
    endcase
  end
end

always_comb begin
  seq_req = '0;
  case( state )
    WR_CTRL: begin
      seq_req.wr                 = 1'b1;
      seq_req.addr               = CTRL;
      seq_req.wdata[CTRL_PHY_EN] = 1'b1;
    end
    WR_ADDR: begin
      seq_req.wr    = 1'b1;
      seq_req.addr  = SCCB_ADDR;
      seq_req.wdata = csr_data_t'(`CSI2_SCCB_ADDR_DEFAULT);
    end
    default: seq_req = '0;
  endcase
end

assign init_done_o = state == DONE;

// Host owns the register bus only after init
assign csr_req_o  = init_done_o ? host_req_i : seq_req;
assign host_rsp_o = '{ rvalid: csr_rsp_i.rvalid && init_done_o, rdata: csr_rsp_i.rdata };

endmodule

//--- csi2_csr.sv
module csi2_csr (
  input                             px_clk_i,
  input                             reset_i,
  input  csi2_csr_pkg::csr_req_t    req_i,
  output csi2_csr_pkg::csr_rsp_t    rsp_o,
  input  csi2_video_pkg::stat_t     stat_i,
  output logic                      phy_en_o,
  output logic                      clear_stat_o,
  output logic                      cam_rst_stb_o,
  output logic [6 : 0]              sccb_slave_addr_o,
  output csi2_csr_pkg::lane_delay_t lane_delay_o,
  output logic                      delay_act_o
);

import csi2_csr_pkg::*;

logic      wr_ctrl;
logic      wr_sccb;
logic      wr_delay;
logic      rvalid;
csr_data_t rdata;
csr_data_t rd_mux;

assign wr_ctrl  = req_i.wr && ( req_i.addr == CTRL );
assign wr_sccb  = req_i.wr && ( req_i.addr == SCCB_ADDR );
assign wr_delay = req_i.wr && ( req_i.addr == LANE_DELAY );

// Self-clearing CTRL bits become single pulses
always_ff @( posedge px_clk_i ) begin
  if( reset_i ) begin
    phy_en_o      <= 1'b0;
    clear_stat_o  <= 1'b0;
    cam_rst_stb_o <= 1'b0;
    delay_act_o   <= 1'b0;
  end else begin
    clear_stat_o  <= wr_ctrl && req_i.wdata[CTRL_CLEAR_STAT];
    cam_rst_stb_o <= wr_ctrl && req_i.wdata[CTRL_CAM_RST];
    delay_act_o   <= wr_delay;
    if( wr_ctrl )
      phy_en_o <= req_i.wdata[CTRL_PHY_EN];
  end
end

always_ff @( posedge px_clk_i ) begin
  if( reset_i ) begin
    sccb_slave_addr_o <= '0;
    lane_delay_o      <= '0;
  end else begin
    if( wr_sccb )
      sccb_slave_addr_o <= req_i.wdata[6 : 0];
    if( wr_delay ) begin
      lane_delay_o.lane_0 <= req_i.wdata[4 : 0];
      lane_delay_o.lane_1 <= req_i.wdata[12 : 8];
    end
  end
end

always_comb begin
  case( req_i.addr )
    CTRL:       rd_mux = csr_data_t'(phy_en_o);
    SCCB_ADDR:  rd_mux = csr_data_t'(sccb_slave_addr_o);
    LANE_DELAY: rd_mux = csr_data_t'({ lane_delay_o.lane_1, 3'b000, lane_delay_o.lane_0 });
    HDR_ERR:    rd_mux = stat_i.header_err_cnt;
    CORR_ERR:   rd_mux = stat_i.corr_err_cnt;
    CRC_ERR:    rd_mux = stat_i.crc_err_cnt;
    MAX_LN:     rd_mux = csr_data_t'(stat_i.max_ln);
    MIN_LN:     rd_mux = csr_data_t'(stat_i.min_ln);
    MAX_PX:     rd_mux = csr_data_t'(stat_i.max_px);
    MIN_PX:     rd_mux = csr_data_t'(stat_i.min_px);
    FPS:        rd_mux = stat_i.fps;
    default:    rd_mux = '0;
  endcase
end

always_ff @( posedge px_clk_i ) begin
  if( reset_i )
    rvalid <= 1'b0;
  else
    rvalid <= req_i.rd;
end

always_ff @( posedge px_clk_i ) begin
  if( req_i.rd )
    rdata <= rd_mux;
end

assign rsp_o = '{ rvalid: rvalid, rdata: rdata };

endmodule

//--- csi2_stat_acc.sv
`include "csi2_cfg.svh"

module csi2_stat_acc (
  input                               px_clk_i,
  input                               reset_i,
  input                               clear_stat_i,
  input  csi2_video_pkg::video_beat_t video_i,
  input  csi2_video_pkg::err_flags_t  err_i,
  output csi2_video_pkg::stat_t       stat_o
);

import csi2_video_pkg::*;

localparam int WIN_W = $clog2(`CSI2_FPS_WINDOW);

logic [WIN_W - 1 : 0] win_cnt;
logic                 win_end;
logic                 beat_sof;
stat_cnt_t            sof_cnt;
stat_cnt_t            hdr_cnt;
stat_cnt_t            corr_cnt;
stat_cnt_t            crc_cnt;
stat_cnt_t            fps;
px_cnt_t              px_cnt;
px_cnt_t              line_len;
px_cnt_t              max_px;
px_cnt_t              min_px;
ln_cnt_t              ln_cnt;
ln_cnt_t              max_ln;
ln_cnt_t              min_ln;
logic                 line_ok;
logic                 frame_ok;

assign beat_sof = video_i.valid && video_i.sof;
assign win_end  = win_cnt == WIN_W'(`CSI2_FPS_WINDOW - 1);

// Length of the line including the current beat
assign line_len = video_i.sof ? px_cnt_t'(1) : px_cnt + 1'b1;

always_ff @( posedge px_clk_i ) begin
  if( reset_i || clear_stat_i ) begin
    hdr_cnt  <= '0;
    corr_cnt <= '0;
    crc_cnt  <= '0;
  end else begin
    hdr_cnt  <= hdr_cnt + err_i.header_err;
    corr_cnt <= corr_cnt + err_i.corr_header_err;
    crc_cnt  <= crc_cnt + err_i.crc_err;
  end
end

always_ff @( posedge px_clk_i ) begin
  if( reset_i || clear_stat_i ) begin
    px_cnt   <= '0;
    ln_cnt   <= '0;
    line_ok  <= 1'b0;
    frame_ok <= 1'b0;
    max_px   <= '0;
    min_px   <= '1;
    max_ln   <= '0;
    min_ln   <= '1;
  end else if( video_i.valid ) begin
    // A line seen only in part is not folded
    if( video_i.eol ) begin
      px_cnt <= '0;
      if( line_ok || video_i.sof ) begin
        if( line_len > max_px )
          max_px <= line_len;
        if( line_len < min_px )
          min_px <= line_len;
      end
    end else begin
      px_cnt <= line_len;
    end
    line_ok <= line_ok || video_i.sof || video_i.eol;

    // Previous frame closes at sof
    if( video_i.sof ) begin
      frame_ok <= 1'b1;
      ln_cnt   <= ln_cnt_t'(video_i.eol);
      if( frame_ok ) begin
        if( ln_cnt > max_ln )
          max_ln <= ln_cnt;
        if( ln_cnt < min_ln )
          min_ln <= ln_cnt;
      end
    end else if( video_i.eol ) begin
      ln_cnt <= ln_cnt + 1'b1;
    end
  end
end

// Window runs free from reset and ignores clear
always_ff @( posedge px_clk_i ) begin
  if( reset_i || win_end ) begin
    win_cnt <= '0;
    sof_cnt <= '0;
  end else begin
    win_cnt <= win_cnt + 1'b1;
    sof_cnt <= sof_cnt + beat_sof;
  end
end

always_ff @( posedge px_clk_i ) begin
  if( reset_i || clear_stat_i )
    fps <= '0;
  else if( win_end )
    fps <= sof_cnt + beat_sof;
end

assign stat_o = '{
  header_err_cnt: hdr_cnt,
  corr_err_cnt:   corr_cnt,
  crc_err_cnt:    crc_cnt,
  max_ln:         max_ln,
  min_ln:         min_ln,
  max_px:         max_px,
  min_px:         min_px,
  fps:            fps
};

endmodule

//--- csi2_csr_pkg.sv
package csi2_csr_pkg;

typedef logic [7 : 0]  csr_addr_t;
typedef logic [31 : 0] csr_data_t;
typedef logic [4 : 0]  dly_tap_t;

typedef struct packed {
  logic      wr;
  logic      rd;
  csr_addr_t addr;
  csr_data_t wdata;
} csr_req_t;

typedef struct packed {
  logic      rvalid;
  csr_data_t rdata;
} csr_rsp_t;

typedef struct packed {
  dly_tap_t lane_1;
  dly_tap_t lane_0;
} lane_delay_t;

// Register map
localparam csr_addr_t CTRL       = 8'h00;
localparam csr_addr_t SCCB_ADDR  = 8'h04;
localparam csr_addr_t LANE_DELAY = 8'h08;
localparam csr_addr_t HDR_ERR    = 8'h10;
localparam csr_addr_t CORR_ERR   = 8'h14;
localparam csr_addr_t CRC_ERR    = 8'h18;
localparam csr_addr_t MAX_LN     = 8'h1c;
localparam csr_addr_t MIN_LN     = 8'h20;
localparam csr_addr_t MAX_PX     = 8'h24;
localparam csr_addr_t MIN_PX     = 8'h28;
localparam csr_addr_t FPS        = 8'h2c;

// CTRL bits
localparam int CTRL_PHY_EN     = 0;
localparam int CTRL_CLEAR_STAT = 1;
localparam int CTRL_CAM_RST    = 2;

endpackage

//--- csi2_video_pkg.sv
package csi2_video_pkg;

typedef logic [31 : 0] stat_cnt_t;
typedef logic [15 : 0] px_cnt_t;
typedef logic [15 : 0] ln_cnt_t;
typedef logic [15 : 0] px_data_t;

// One beat of the receiver video stream
typedef struct packed {
  logic     valid;
  logic     sof;
  logic     eol;
  px_data_t data;
} video_beat_t;

typedef struct packed {
  logic header_err;
  logic corr_header_err;
  logic crc_err;
} err_flags_t;

typedef struct packed {
  stat_cnt_t header_err_cnt;
  stat_cnt_t corr_err_cnt;
  stat_cnt_t crc_err_cnt;
  ln_cnt_t   max_ln;
  ln_cnt_t   min_ln;
  px_cnt_t   max_px;
  px_cnt_t   min_px;
  stat_cnt_t fps;
} stat_t;

endpackage

//--- csi2_cfg.svh
`ifndef CSI2_CFG_SVH
`define CSI2_CFG_SVH

// Frame rate measurement window in px_clk cycles
`define CSI2_FPS_WINDOW 2000

// Camera held in power-down after reset or cam_rst
`define CSI2_PWUP_DELAY 50

// Sensor SCCB address loaded during init
`define CSI2_SCCB_ADDR_DEFAULT 7'h1a

`endif
